/* hw/audio_params.svh */
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// clk_m cycles per half period of the mic bit clock
// 4 gives an 8 clock sck period, about 12.3 MHz at 98.304 MHz
`define AUDIO_SCK_HALF 4

// sck periods per ws half, left slot then right slot
// one sample every 2 * 32 sck periods
`define AUDIO_SLOT_BITS 32

// accepted samples per energy frame
`define AUDIO_FRAME_LEN 8

`endif

/* hw/audio_pkg.sv */
package audio_pkg;

  // one signed pcm word from the left microphone slot
  typedef logic signed [15:0] sample_t;

  // sum of squared samples over one frame
  // unsigned, pinned at all ones on overflow
  typedef logic [31:0] energy_t;

  // word index on the wishbone register port
  typedef enum logic [1:0] {
    // enable and gain shift
    REG_CTRL   = 2'd0,
    // detection threshold
    REG_THRESH = 2'd1,
    // last completed frame energy, read only
    REG_ENERGY = 2'd2,
    // detected, overrun and frame count, read only
    REG_STATUS = 2'd3
  } reg_addr_e;

endpackage

/* hw/mic_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "audio_params.svh"

module mic_capture
  import audio_pkg::*;
(
  input  wire     clk_m,
  input  wire     sys_rst,
  input  wire     mic_data,
  input  wire     sample_ready,
  input  wire     overrun_clr,
  output logic    mic_sck,
  output logic    mic_ws,
  output sample_t sample,
  output logic    sample_valid,
  output logic    sample_strobe,
  output logic    overrun
);

  localparam int DIV_W  = $clog2(`AUDIO_SCK_HALF);
  localparam int SLOT_W = $clog2(`AUDIO_SLOT_BITS);
  localparam int SMP_W  = $bits(sample_t);

  localparam logic [DIV_W-1:0]  DIV_LAST  = DIV_W'(`AUDIO_SCK_HALF - 1);
  localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(`AUDIO_SLOT_BITS - 1);
  // slot bit 0 is the i2s delay bit, data follows msb first
  localparam logic [SLOT_W-1:0] BIT_FIRST = SLOT_W'(1);
  localparam logic [SLOT_W-1:0] BIT_LAST  = SLOT_W'(SMP_W);

  logic [DIV_W-1:0]  div_cnt;
  logic [SLOT_W-1:0] bit_idx;
  logic [SMP_W-2:0]  shreg;
  logic              div_done;
  logic              sck_rise;
  logic              sck_fall;
  logic              in_sample;
  logic              slot_done;
  logic              take;

  assign div_done = (div_cnt == DIV_LAST);
  // edge events seen one clock before sck itself changes
  assign sck_rise = div_done && !mic_sck;
  assign sck_fall = div_done && mic_sck;

  // only the left slot is kept
  assign in_sample = !mic_ws && (bit_idx >= BIT_FIRST) && (bit_idx <= BIT_LAST);
  assign slot_done = sck_rise && in_sample && (bit_idx == BIT_LAST);
  assign take      = sample_valid && sample_ready;

  // bit clock divider
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      div_cnt <= '0;
      mic_sck <= 1'b0;
    end else begin
      div_cnt <= div_done ? '0 : div_cnt + 1'b1;
      if (div_done) begin
        mic_sck <= ~mic_sck;
      end
    end
  end

  // slot bit position and word select, both move on falling sck
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      bit_idx <= '0;
      mic_ws  <= 1'b0;
    end else if (sck_fall) begin
      if (bit_idx == SLOT_LAST) begin
        bit_idx <= '0;
        mic_ws  <= ~mic_ws;
      end else begin
        bit_idx <= bit_idx + 1'b1;
      end
    end
  end

  // deserializer, mic_data sampled at rising sck
  always_ff @(posedge clk_m) begin
    if (sck_rise && in_sample) begin
      shreg <= {shreg[SMP_W-3:0], mic_data};
    end
  end

  // output word, last bit goes straight in
  always_ff @(posedge clk_m) begin
    if (slot_done) begin
      sample <= {shreg, mic_data};
    end
  end

  // valid/ready handshake and overrun flag
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      sample_valid  <= 1'b0;
      sample_strobe <= 1'b0;
      overrun       <= 1'b0;
    end else begin
      sample_strobe <= slot_done;
      if (slot_done) begin
        sample_valid <= 1'b1;
      end else if (take) begin
        sample_valid <= 1'b0;
      end
      // new word while old one still pending, old one is lost
      if (slot_done && sample_valid && !sample_ready) begin
        overrun <= 1'b1;
      end else if (overrun_clr) begin
        overrun <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/pdm_modulator.sv */
`timescale 1ns/1ps
`default_nettype none

module pdm_modulator
  import audio_pkg::*;
(
  input  wire     clk_m,
  input  wire     sys_rst,
  input  sample_t level,
  input  wire     level_strobe,
  output logic    pdm_out
);

  localparam int LVL_W = $bits(sample_t);

  // held level in offset binary, 0 is most negative
  logic [LVL_W-1:0] level_q;
  logic [LVL_W-1:0] acc;
  logic [LVL_W:0]   acc_sum;

  assign acc_sum = {1'b0, acc} + {1'b0, level_q};

  // latch new level, sign bit flipped
  // output idles low until the first sample arrives
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      level_q <= '0;
    end else if (level_strobe) begin
      level_q <= {~level[LVL_W-1], level[LVL_W-2:0]};
    end
  end

  // first order sigma-delta, carry out is the pdm bit
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      acc     <= '0;
      pdm_out <= 1'b0;
    end else begin
      acc     <= acc_sum[LVL_W-1:0];
      pdm_out <= acc_sum[LVL_W];
    end
  end

endmodule

`default_nettype wire

/* hw/frame_energy.sv */
`timescale 1ns/1ps
`default_nettype none

`include "audio_params.svh"

module frame_energy
  import audio_pkg::*;
(
  input  wire        clk_m,
  input  wire        sys_rst,
  input  sample_t    sample,
  input  wire        sample_valid,
  input  wire        enable,
  input  wire  [3:0] gain_shift,
  input  energy_t    threshold,
  output logic       sample_ready,
  output energy_t    frame_energy_q,
  output logic [7:0] frame_count,
  output logic       detected
);

  localparam int CNT_W = $clog2(`AUDIO_FRAME_LEN);
  localparam int SQ_W  = 2 * $bits(sample_t);
  localparam int EN_W  = $bits(energy_t);

  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`AUDIO_FRAME_LEN - 1);

  logic [CNT_W-1:0]  sample_idx;
  energy_t           acc;
  energy_t           acc_next;
  sample_t           scaled;
  logic signed [SQ_W-1:0] square;
  logic [EN_W:0]     sum_wide;
  logic              accept;
  logic              frame_end;

  // disabled means back-pressure toward the capture block
  assign sample_ready = enable;
  assign accept       = sample_valid && sample_ready;
  assign frame_end    = accept && (sample_idx == LAST_IDX);

  // arithmetic shift keeps the sign
  assign scaled = sample >>> gain_shift;
  // square of a 16 bit signed word is at most 2**30
  assign square = scaled * scaled;

  // one extra bit catches the wrap, then pin at all ones
  assign sum_wide = {1'b0, acc} + {1'b0, energy_t'(square)};
  assign acc_next = sum_wide[EN_W] ? '1 : sum_wide[EN_W-1:0];

  // running sum and position in the frame
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      acc        <= '0;
      sample_idx <= '0;
    end else if (!enable) begin
      // partial frame dropped
      acc        <= '0;
      sample_idx <= '0;
    end else if (accept) begin
      if (frame_end) begin
        acc        <= '0;
        sample_idx <= '0;
      end else begin
        acc        <= acc_next;
        sample_idx <= sample_idx + 1'b1;
      end
    end
  end

  // frame results, updated once per full frame
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      frame_energy_q <= '0;
      detected       <= 1'b0;
      frame_count    <= '0;
    end else if (frame_end) begin
      frame_energy_q <= acc_next;
      // strictly above, equal does not trigger
      detected       <= (acc_next > threshold);
      // wraps at 256
      frame_count    <= frame_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/audio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_regs
  import audio_pkg::*;
(
  input  wire         clk_m,
  input  wire         sys_rst,
  input  wire         wb_cyc,
  input  wire         wb_stb,
  input  wire         wb_we,
  input  wire  [1:0]  wb_adr,
  input  wire  [31:0] wb_dat_w,
  input  energy_t     frame_energy_q,
  input  wire  [7:0]  frame_count,
  input  wire         detected,
  input  wire         overrun,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  output logic        enable,
  output logic [3:0]  gain_shift,
  output energy_t     threshold,
  output logic        overrun_clr
);

  reg_addr_e   addr;
  logic        req;
  logic        wr;
  logic [31:0] rd_word;

  assign addr = reg_addr_e'(wb_adr);
  // new cycle seen, ack not yet given
  assign req  = wb_cyc && wb_stb && !wb_ack;
  assign wr   = req && wb_we;

  // read mux from live register and status values
  always_comb begin
    rd_word = '0;
    case (addr)
      REG_CTRL: begin
        rd_word[0]   = enable;
        rd_word[4:1] = gain_shift;
      end
      REG_THRESH: begin
        rd_word = threshold;
      end
      REG_ENERGY: begin
        rd_word = frame_energy_q;
      end
      REG_STATUS: begin
        rd_word[0]    = detected;
        rd_word[1]    = overrun;
        rd_word[15:8] = frame_count;
      end
      default: begin
        rd_word = '0;
      end
    endcase
  end

  // single cycle ack, never back to back
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // read data captured with the ack
  always_ff @(posedge clk_m) begin
    if (req) begin
      wb_dat_r <= rd_word;
    end
  end

  // writable words, energy and status writes fall through
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      enable      <= 1'b0;
      gain_shift  <= '0;
      threshold   <= '0;
      overrun_clr <= 1'b0;
    end else begin
      overrun_clr <= 1'b0;
      if (wr && addr == REG_CTRL) begin
        enable      <= wb_dat_w[0];
        gain_shift  <= wb_dat_w[4:1];
        // any ctrl write also drops the sticky overrun
        overrun_clr <= 1'b1;
      end
      if (wr && addr == REG_THRESH) begin
        threshold <= wb_dat_w;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/audio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_top
  import audio_pkg::*;
(
  input  wire         clk_m,
  input  wire         sys_rst,
  input  wire         mic_data,
  input  wire         wb_cyc,
  input  wire         wb_stb,
  input  wire         wb_we,
  input  wire  [1:0]  wb_adr,
  input  wire  [31:0] wb_dat_w,
  output logic        mic_sck,
  output logic        mic_ws,
  output logic        spk,
  output logic        detected,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  // capture to detector and playback
  sample_t    sample;
  logic       sample_valid;
  logic       sample_ready;
  logic       sample_strobe;
  logic       overrun;
  logic       overrun_clr;

  // register block controls and status
  logic       enable;
  logic [3:0] gain_shift;
  energy_t    threshold;
  energy_t    frame_energy_q;
  logic [7:0] frame_count;

  mic_capture u_mic_capture (
    .clk_m         (clk_m),
    .sys_rst       (sys_rst),
    .mic_data      (mic_data),
    .sample_ready  (sample_ready),
    .overrun_clr   (overrun_clr),
    .mic_sck       (mic_sck),
    .mic_ws        (mic_ws),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .sample_strobe (sample_strobe),
    .overrun       (overrun)
  );

  // speaker follows every sample, taken downstream or not
  pdm_modulator u_pdm_modulator (
    .clk_m        (clk_m),
    .sys_rst      (sys_rst),
    .level        (sample),
    .level_strobe (sample_strobe),
    .pdm_out      (spk)
  );

  frame_energy u_frame_energy (
    .clk_m          (clk_m),
    .sys_rst        (sys_rst),
    .sample         (sample),
    .sample_valid   (sample_valid),
    .enable         (enable),
    .gain_shift     (gain_shift),
    .threshold      (threshold),
    .sample_ready   (sample_ready),
    .frame_energy_q (frame_energy_q),
    .frame_count    (frame_count),
    .detected       (detected)
  );

  audio_regs u_audio_regs (
    .clk_m          (clk_m),
    .sys_rst        (sys_rst),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .frame_energy_q (frame_energy_q),
    .frame_count    (frame_count),
    .detected       (detected),
    .overrun        (overrun),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .enable         (enable),
    .gain_shift     (gain_shift),
    .threshold      (threshold),
    .overrun_clr    (overrun_clr)
  );

endmodule

`default_nettype wire

/* tests/audio_props.sv */
`timescale 1ns/1ps

`include "audio_params.svh"

module audio_props
  import audio_pkg::*;
(
  input wire     clk_m,
  input wire     sys_rst,
  input wire     wb_cyc,
  input wire     wb_stb,
  input wire     wb_ack,
  input wire     mic_sck,
  input sample_t sample,
  input wire     sample_valid,
  input wire     sample_ready,
  input wire     sample_strobe
);

  int prop_errors;

  initial prop_errors = 0;

  // ack only answers a live request
  ack_needs_request: assert property (@(posedge clk_m) disable iff (sys_rst)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb)
  ) else begin
    $error("wishbone ack raised without cyc and stb");
    prop_errors++;
  end

  // single cycle ack
  ack_one_cycle: assert property (@(posedge clk_m) disable iff (sys_rst)
    wb_ack |=> !wb_ack
  ) else begin
    $error("wishbone ack high on two cycles in a row");
    prop_errors++;
  end

  // pending word held, only a new slot may replace it
  sample_held: assert property (@(posedge clk_m) disable iff (sys_rst)
    sample_valid && !sample_ready |=> sample_valid && ($stable(sample) || sample_strobe)
  ) else begin
    $error("pending sample dropped or changed before it was taken");
    prop_errors++;
  end

  // bit clock period
  sck_period: assert property (@(posedge clk_m) disable iff (sys_rst)
    $rose(mic_sck) |-> ##(`AUDIO_SCK_HALF) $fell(mic_sck) ##(`AUDIO_SCK_HALF) $rose(mic_sck)
  ) else begin
    $error("mic bit clock period differs from two half periods");
    prop_errors++;
  end

endmodule

bind audio_top audio_props u_audio_props (.*);

/* tests/audio_tb.sv */
`timescale 1ns/1ps

`include "audio_params.svh"

module audio_tb
  import audio_pkg::*;
();

  localparam int SMP_BITS     = $bits(sample_t);
  // one left and one right slot per sample
  localparam int SAMPLE_CLKS  = 4 * `AUDIO_SLOT_BITS * `AUDIO_SCK_HALF;
  // 12 frames worth of samples plus 20 percent
  localparam int TIMEOUT_CLKS = 12 * `AUDIO_FRAME_LEN * SAMPLE_CLKS * 6 / 5;
  localparam longint ENERGY_MAX = 64'h0000_0000_ffff_ffff;

  logic        clk_m;
  logic        sys_rst;
  logic        mic_data;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic        mic_sck;
  logic        mic_ws;
  logic        spk;
  logic        detected;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  // words waiting for the microphone model, and the frame being built
  sample_t     mic_queue[$];
  sample_t     frame_buf[`AUDIO_FRAME_LEN];
  sample_t     cur_word;
  logic        cur_real;
  int          slot_pos;
  int          slots_done;
  int          real_done;
  logic [31:0] rng_state;
  logic [7:0]  exp_frames;
  int          cycle_count;
  int          check_count;
  int          error_count;

  audio_top u_audio_top (.*);

  initial clk_m = 1'b0;
  always #5 clk_m = ~clk_m;

  // i2s microphone, next bit shows up after each falling sck
  always @(negedge mic_sck) begin
    if (!sys_rst) begin
      slot_pos = (slot_pos + 1) % (2 * `AUDIO_SLOT_BITS);
      if (slot_pos == 1) begin
        cur_real = (mic_queue.size() != 0);
        if (cur_real) begin
          cur_word = mic_queue.pop_front();
        end else begin
          cur_word = '0;
        end
      end
      // bit 0 is the delay bit, msb first after it
      if (slot_pos >= 1 && slot_pos <= SMP_BITS) begin
        mic_data <= cur_word[SMP_BITS - slot_pos];
      end else begin
        mic_data <= 1'b0;
      end
      // last sample bit went in at the previous rising sck
      if (slot_pos == SMP_BITS + 1) begin
        slots_done++;
        if (cur_real) begin
          real_done++;
        end
      end
    end
  end

  // word select low for the left slot, high for the right one
  always @(negedge clk_m) begin
    if (!sys_rst) begin
      assert (mic_ws === (slot_pos >= `AUDIO_SLOT_BITS)) else begin
        error_count++;
        $display("Fail mic_ws: expected %b, actual %b", slot_pos >= `AUDIO_SLOT_BITS,
                 mic_ws);
      end
    end
  end

  // run limit
  always @(posedge clk_m) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CLKS) begin
      $display("timeout: tests still running after %0d clocks", TIMEOUT_CLKS);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  // shift, square, clamp at 32 bits, sum over one frame
  function automatic logic [31:0] expected_energy(input sample_t smp[`AUDIO_FRAME_LEN],
                                                  input int shift);
    longint sum;
    int     v;
    sum = 0;
    for (int i = 0; i < `AUDIO_FRAME_LEN; i++) begin
      v   = int'(smp[i]) >>> shift;
      sum = sum + longint'(v) * longint'(v);
      if (sum > ENERGY_MAX) begin
        sum = ENERGY_MAX;
      end
    end
    return sum[31:0];
  endfunction

  // ones from an accumulator that adds the offset level every clock
  function automatic int expected_pdm(input logic [15:0] acc0, input sample_t level,
                                      input int n);
    logic [16:0] sum;
    logic [15:0] acc;
    logic [15:0] off;
    int          ones;
    acc  = acc0;
    // offset binary, half scale added
    off  = level + 16'h8000;
    ones = 0;
    for (int k = 0; k < n; k++) begin
      sum  = {1'b0, acc} + {1'b0, off};
      ones = ones + sum[16];
      acc  = sum[15:0];
    end
    return ones;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    check_count++;
    assert (act_val === exp_val) else begin
      error_count++;
      $display("Fail %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  // ack is seen at an edge and the bus is released at that same edge
  task automatic wait_ack();
    do begin
      @(posedge clk_m);
    end while (!wb_ack);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input reg_addr_e adr, input logic [31:0] data);
    @(posedge clk_m);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= data;
    wait_ack();
  endtask

  task automatic wb_read(input reg_addr_e adr, output logic [31:0] data);
    @(posedge clk_m);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_ack();
    data = wb_dat_r;
  endtask

  task automatic fill_frame(input logic full_scale);
    logic [31:0] r;
    for (int i = 0; i < `AUDIO_FRAME_LEN; i++) begin
      r = lcg_next();
      frame_buf[i] = full_scale ? 16'sh8000 : sample_t'(r[30:15]);
    end
  endtask

  // send frame_buf as one detector frame, then compare energy and status
  task automatic run_frame(input string name, input logic [3:0] shift,
                           input logic [31:0] thresh);
    logic [31:0] exp_e;
    logic [31:0] energy;
    logic [31:0] status;
    int          base;
    exp_e = expected_energy(frame_buf, shift);
    // detector off drops any partial frame
    wb_write(REG_CTRL, 32'h0);
    wb_write(REG_THRESH, thresh);
    base = real_done;
    foreach (frame_buf[i]) mic_queue.push_back(frame_buf[i]);
    // first word sits pending until the detector is on
    wait (real_done == base + 1);
    wb_write(REG_CTRL, {27'd0, shift, 1'b1});
    wait (real_done == base + `AUDIO_FRAME_LEN);
    repeat (2) @(posedge clk_m);
    exp_frames++;
    wb_read(REG_ENERGY, energy);
    wb_read(REG_STATUS, status);
    check_value({name, " energy"}, exp_e, energy);
    check_value({name, " detected bit"}, {31'd0, exp_e > thresh}, {31'd0, status[0]});
    check_value({name, " detected pin"}, {31'd0, exp_e > thresh}, {31'd0, detected});
    check_value({name, " frame count"}, {24'd0, exp_frames}, {24'd0, status[15:8]});
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] exp_e;
    logic [15:0] acc0;
    sample_t     pdm_level;
    int          mark;
    int          ones;
    int          approx;
    longint      err_scaled;
    sys_rst     = 1'b1;
    mic_data    = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    rng_state   = 32'd17985;
    slot_pos    = 0;
    slots_done  = 0;
    real_done   = 0;
    cur_real    = 1'b0;
    cur_word    = '0;
    exp_frames  = '0;
    cycle_count = 0;
    check_count = 0;
    error_count = 0;
    repeat (3) @(posedge clk_m);
    sys_rst <= 1'b0;

    // register access
    wb_write(REG_THRESH, 32'ha5c3_1e77);
    wb_read(REG_THRESH, rd);
    check_value("thresh readback", 32'ha5c3_1e77, rd);
    wb_write(REG_CTRL, 32'h0000_0015);
    wb_read(REG_CTRL, rd);
    check_value("ctrl readback", 32'h0000_0015, rd);
    wb_write(REG_CTRL, 32'h0);
    // no frame completed yet, energy still holds its reset value
    wb_write(REG_ENERGY, 32'hdead_beef);
    wb_read(REG_ENERGY, rd);
    check_value("energy write ignored", 32'h0, rd);

    // energy, gain and saturation
    repeat (2) begin
      fill_frame(1'b0);
      run_frame("gain 0", 4'd0, 32'hffff_ffff);
    end
    fill_frame(1'b0);
    run_frame("gain 3", 4'd3, 32'hffff_ffff);
    fill_frame(1'b1);
    run_frame("saturation", 4'd0, 32'h0);

    // threshold, shift 1 keeps the sum below saturation
    fill_frame(1'b0);
    exp_e = expected_energy(frame_buf, 1);
    run_frame("threshold below", 4'd1, exp_e - 1);
    fill_frame(1'b0);
    exp_e = expected_energy(frame_buf, 1);
    run_frame("threshold above", 4'd1, exp_e + 1);
    fill_frame(1'b0);
    exp_e = expected_energy(frame_buf, 1);
    run_frame("threshold equal", 4'd1, exp_e);

    // back-pressure, second pending word sets overrun
    wb_write(REG_CTRL, 32'h0);
    mark = slots_done;
    wait (slots_done == mark + 2);
    wb_read(REG_STATUS, rd);
    check_value("overrun set", 32'd1, {31'd0, rd[1]});
    check_value("frame count frozen", {24'd0, exp_frames}, {24'd0, rd[15:8]});
    wb_write(REG_CTRL, 32'h0);
    wb_read(REG_STATUS, rd);
    check_value("overrun cleared", 32'd0, {31'd0, rd[1]});

    // pdm density over 1024 clocks at a constant level
    pdm_level = -16'sd9000;
    mark = real_done;
    repeat (4) mic_queue.push_back(pdm_level);
    wait (real_done == mark + 1);
    @(negedge clk_m);
    acc0 = u_audio_top.u_pdm_modulator.acc;
    ones = 0;
    repeat (1024) begin
      @(negedge clk_m);
      ones = ones + spk;
    end
    check_value("pdm ones", expected_pdm(acc0, pdm_level, 1024), ones);
    approx     = 1024 * (int'(pdm_level) + 32768) / 65536;
    err_scaled = longint'(ones) * 65536 - 1024 * (longint'(pdm_level) + 32768);
    check_count++;
    assert (err_scaled <= 2 * 65536 && err_scaled >= -2 * 65536) else begin
      error_count++;
      $display("Fail pdm density: expected %0d +/- 2, actual %0d", approx, ones);
    end

    $display("checks %0d, errors %0d, assertion errors %0d", check_count, error_count,
             u_audio_top.u_audio_props.prop_errors);
    if (error_count == 0 && u_audio_top.u_audio_props.prop_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+hw
hw/audio_pkg.sv
hw/mic_capture.sv
hw/pdm_modulator.sv
hw/frame_energy.sv
hw/audio_regs.sv
hw/audio_top.sv
tests/audio_props.sv
tests/audio_tb.sv
